// File: rtl/soc_bus_pkg.sv
// APB request and response types with bus widths, imported by every RTL block and the testbench
package soc_bus_pkg;

    ////////////////////
    // Bus widths
    ////////////////////

    localparam int unsigned AddrWidth = 32;
    localparam int unsigned DataWidth = 32;

    typedef logic [AddrWidth-1:0] addr_t;
    typedef logic [DataWidth-1:0] data_t;

    ////////////////////
    // APB channels
    ////////////////////

    // Master to slave, 67 bits
    typedef struct packed {
        logic  psel;
        logic  penable;
        logic  pwrite;
        addr_t paddr;
        data_t pwdata;
    } apb_req_t;

    // Slave to master, 34 bits
    // pready and pslverr are only meaningful in the access cycle
    typedef struct packed {
        data_t prdata;
        logic  pready;
        logic  pslverr;
    } apb_resp_t;

endpackage

// File: rtl/soc_map_pkg.sv
// Address map, register offsets, reset values and interrupt positions of the peripheral subsystem
package soc_map_pkg;

    ////////////////////
    // Slave windows
    ////////////////////

    typedef enum logic [1:0] {
        SLV_CTRL,
        SLV_EVT,
        SLV_IRQ,
        SLV_NONE
    } apb_slave_e;

    localparam logic [31:0] CtrlStart = 32'h1A10_4000;
    localparam logic [31:0] CtrlEnd   = 32'h1A10_4FFF;
    localparam logic [31:0] EvtStart  = 32'h1A10_6000;
    localparam logic [31:0] EvtEnd    = 32'h1A10_6FFF;
    localparam logic [31:0] IrqStart  = 32'h1A10_9000;
    localparam logic [31:0] IrqEnd    = 32'h1A10_9FFF;

    // Word offsets inside a 4 KiB window
    typedef enum logic [11:0] {
        OFF_BOOTADDR = 12'h000,
        OFF_FETCHEN  = 12'h004,
        OFF_CLUSTER  = 12'h008
    } reg_off_e;

    // The event and mask slaves hold one register each, at word zero
    localparam reg_off_e OFF_EVT_TRIG = reg_off_e'(12'h000);
    localparam reg_off_e OFF_IRQ_MASK = reg_off_e'(12'h000);

    ////////////////////
    // Reset values and sizes
    ////////////////////

    localparam int unsigned NumIrq          = 32;
    localparam int unsigned NumSwEvt        = 8;
    localparam int unsigned NumAdvTimerEvt  = 4;
    localparam int unsigned NumHwpeEvt      = 2;

    localparam logic [31:0]       BootAddrRst = 32'h1A00_0080;
    localparam logic [NumIrq-1:0] IrqMaskRst  = '1;

    // Fixed positions in the fabric controller interrupt vector
    localparam int unsigned IrqDmaPeEvt = 8;
    localparam int unsigned IrqDmaPeIrq = 9;
    localparam int unsigned IrqPfEvt    = 12;
    localparam int unsigned IrqRefClk   = 14;
    localparam int unsigned IrqGpio     = 15;
    localparam int unsigned IrqAdvTimer = 17;
    localparam int unsigned IrqHwpe     = 30;

    // Bits 10, 11, 13, 16 and 21 to 29 have no source
    localparam logic [NumIrq-1:0] IrqReservedMask = 32'h3FE1_2C00;

    // rstn sits in bit 0, pow in bit 3
    typedef struct packed {
        logic pow;
        logic byp;
        logic fetch_en;
        logic rstn;
    } cluster_ctrl_t;

endpackage

// File: rtl/apb_addr_decode.sv
// APB address decoder that routes the subsystem port to one of three register slaves
`timescale 1ns/1ns

module apb_addr_decode
    import soc_bus_pkg::*;
    import soc_map_pkg::*;
(
    input  apb_req_t  apb_req_i,
    output apb_resp_t apb_resp_o,
    output apb_req_t  ctrl_req_o,
    output apb_req_t  evt_req_o,
    output apb_req_t  irq_req_o,
    input  apb_resp_t ctrl_resp_i,
    input  apb_resp_t evt_resp_i,
    input  apb_resp_t irq_resp_i
);

    apb_slave_e slv_sel;

    // Window match
    always_comb begin
        if (apb_req_i.paddr >= CtrlStart && apb_req_i.paddr <= CtrlEnd) begin
            slv_sel = SLV_CTRL;
        end else if (apb_req_i.paddr >= EvtStart && apb_req_i.paddr <= EvtEnd) begin
            slv_sel = SLV_EVT;
        end else if (apb_req_i.paddr >= IrqStart && apb_req_i.paddr <= IrqEnd) begin
            slv_sel = SLV_IRQ;
        end else begin
            slv_sel = SLV_NONE;
        end
    end

    // Same request to all slaves, only psel is qualified
    always_comb begin
        ctrl_req_o      = apb_req_i;
        evt_req_o       = apb_req_i;
        irq_req_o       = apb_req_i;
        ctrl_req_o.psel = apb_req_i.psel & (slv_sel == SLV_CTRL);
        evt_req_o.psel  = apb_req_i.psel & (slv_sel == SLV_EVT);
        irq_req_o.psel  = apb_req_i.psel & (slv_sel == SLV_IRQ);
    end

    always_comb begin
        case (slv_sel)
            SLV_CTRL: apb_resp_o = ctrl_resp_i;
            SLV_EVT:  apb_resp_o = evt_resp_i;
            SLV_IRQ:  apb_resp_o = irq_resp_i;
            default: begin
                // Unmapped: complete at once with an error
                apb_resp_o.prdata  = '0;
                apb_resp_o.pready  = 1'b1;
                apb_resp_o.pslverr = 1'b1;
            end
        endcase
    end

    // Checked when an access phase starts, selects are stable since setup
    a_one_slave : assert property (@(posedge apb_req_i.penable)
        $onehot0({ctrl_req_o.psel, evt_req_o.psel, irq_req_o.psel}))
        else $error("more than one APB slave selected");

endmodule

// File: rtl/soc_ctrl_regs.sv
// SoC control slave holding boot address, fetch enable and cluster control for the FC
`timescale 1ns/1ns

module soc_ctrl_regs
    import soc_bus_pkg::*;
    import soc_map_pkg::*;
(
    input  logic          clk_i,
    input  logic          rst_ni,
    input  apb_req_t      apb_req_i,
    output apb_resp_t     apb_resp_o,
    input  logic          fc_fetch_en_valid_i,
    input  logic          fc_fetch_en_i,
    output addr_t         fc_bootaddr_o,
    output logic          fc_fetchen_o,
    output cluster_ctrl_t cluster_ctrl_o
);

    reg_off_e      reg_off;
    logic          wr_en;
    addr_t         bootaddr_q;
    logic          fetchen_q;
    cluster_ctrl_t cluster_q;

    assign reg_off = reg_off_e'(apb_req_i.paddr[11:0]);
    assign wr_en   = apb_req_i.psel & apb_req_i.penable & apb_req_i.pwrite;

    ////////////////////
    // Registers
    ////////////////////

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            bootaddr_q <= BootAddrRst;
            fetchen_q  <= 1'b0;
            cluster_q  <= '0;
        end else begin
            if (wr_en && reg_off == OFF_BOOTADDR) begin
                bootaddr_q <= apb_req_i.pwdata;
            end
            // Hardware strobe has priority over the bus
            if (fc_fetch_en_valid_i) begin
                fetchen_q <= fc_fetch_en_i;
            end else if (wr_en && reg_off == OFF_FETCHEN) begin
                fetchen_q <= apb_req_i.pwdata[0];
            end
            if (wr_en && reg_off == OFF_CLUSTER) begin
                cluster_q <= cluster_ctrl_t'(apb_req_i.pwdata[3:0]);
            end
        end
    end

    // Zero wait states
    always_comb begin
        apb_resp_o.pready  = apb_req_i.psel & apb_req_i.penable;
        apb_resp_o.pslverr = 1'b0;
        case (reg_off)
            OFF_BOOTADDR: apb_resp_o.prdata = bootaddr_q;
            OFF_FETCHEN:  apb_resp_o.prdata = data_t'(fetchen_q);
            OFF_CLUSTER:  apb_resp_o.prdata = data_t'(cluster_q);
            default:      apb_resp_o.prdata = '0;
        endcase
    end

    assign fc_bootaddr_o  = bootaddr_q;
    assign fc_fetchen_o   = fetchen_q;
    assign cluster_ctrl_o = cluster_q;

    a_pready_known : assert property (@(posedge clk_i) disable iff (!rst_ni)
        apb_req_i.psel |-> !$isunknown(apb_resp_o.pready))
        else $error("pready unknown during a selected transfer");

endmodule

// File: rtl/soc_event_unit.sv
// Event slave that turns slow clock edges into pulses and lets software fire event pulses
`timescale 1ns/1ns

module soc_event_unit
    import soc_bus_pkg::*;
    import soc_map_pkg::*;
(
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                slow_clk_i,
    input  apb_req_t            apb_req_i,
    output apb_resp_t           apb_resp_o,
    output logic [NumSwEvt-1:0] sw_evt_o,
    output logic                ref_edge_o
);

    logic                slow_q1;
    logic                slow_q2;
    logic                slow_q3;
    logic                trig_hit;
    logic                trig_wr;
    logic [NumSwEvt-1:0] sw_evt_q;
    logic [NumSwEvt-1:0] evt_last_q;

    ////////////////////
    // Reference clock
    ////////////////////

    // Two synchronizer stages, the third flop keeps the previous level
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            slow_q1 <= 1'b0;
            slow_q2 <= 1'b0;
            slow_q3 <= 1'b0;
        end else begin
            slow_q1 <= slow_clk_i;
            slow_q2 <= slow_q1;
            slow_q3 <= slow_q2;
        end
    end

    // Rising and falling edges both count
    assign ref_edge_o = slow_q2 ^ slow_q3;

    ////////////////////
    // Software trigger
    ////////////////////

    assign trig_hit = (reg_off_e'(apb_req_i.paddr[11:0]) == OFF_EVT_TRIG);
    assign trig_wr  = apb_req_i.psel & apb_req_i.penable & apb_req_i.pwrite & trig_hit;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            sw_evt_q   <= '0;
            evt_last_q <= '0;
        end else begin
            // Pulse lasts one cycle, cleared on the next edge
            sw_evt_q <= trig_wr ? apb_req_i.pwdata[NumSwEvt-1:0] : '0;
            if (trig_wr) begin
                evt_last_q <= apb_req_i.pwdata[NumSwEvt-1:0];
            end
        end
    end

    assign sw_evt_o = sw_evt_q;

    always_comb begin
        apb_resp_o.pready  = apb_req_i.psel & apb_req_i.penable;
        apb_resp_o.pslverr = 1'b0;
        apb_resp_o.prdata  = trig_hit ? data_t'(evt_last_q) : '0;
    end

    a_sw_evt_pulse : assert property (@(posedge clk_i) disable iff (!rst_ni)
        (sw_evt_o != '0) |=> (sw_evt_o == '0))
        else $error("software event held longer than one cycle");

endmodule

// File: rtl/fc_irq_mapper.sv
// Interrupt mapper that builds, masks and registers the FC interrupt vector, with its mask slave
`timescale 1ns/1ns

module fc_irq_mapper
    import soc_bus_pkg::*;
    import soc_map_pkg::*;
(
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  apb_req_t                  apb_req_i,
    output apb_resp_t                 apb_resp_o,
    input  logic [NumSwEvt-1:0]       sw_evt_i,
    input  logic                      ref_edge_i,
    input  logic                      dma_pe_evt_i,
    input  logic                      dma_pe_irq_i,
    input  logic                      pf_evt_i,
    input  logic                      gpio_evt_i,
    input  logic [NumAdvTimerEvt-1:0] adv_timer_evt_i,
    input  logic [NumHwpeEvt-1:0]     fc_hwpe_evt_i,
    output logic [NumIrq-1:0]         fc_interrupts_o
);

    logic              mask_hit;
    logic              mask_wr;
    logic [NumIrq-1:0] mask_q;
    logic [NumIrq-1:0] irq_vec;
    logic [NumIrq-1:0] irq_q;

    ////////////////////
    // Vector assembly
    ////////////////////

    always_comb begin
        irq_vec                                  = '0;
        irq_vec[NumSwEvt-1:0]                    = sw_evt_i;
        irq_vec[IrqDmaPeEvt]                     = dma_pe_evt_i;
        irq_vec[IrqDmaPeIrq]                     = dma_pe_irq_i;
        irq_vec[IrqPfEvt]                        = pf_evt_i;
        irq_vec[IrqRefClk]                       = ref_edge_i;
        irq_vec[IrqGpio]                         = gpio_evt_i;
        irq_vec[IrqAdvTimer +: NumAdvTimerEvt]   = adv_timer_evt_i;
        irq_vec[IrqHwpe +: NumHwpeEvt]           = fc_hwpe_evt_i;
    end

    // Mask register
    assign mask_hit = (reg_off_e'(apb_req_i.paddr[11:0]) == OFF_IRQ_MASK);
    assign mask_wr  = apb_req_i.psel & apb_req_i.penable & apb_req_i.pwrite & mask_hit;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mask_q <= IrqMaskRst;
            irq_q  <= '0;
        end else begin
            if (mask_wr) begin
                mask_q <= apb_req_i.pwdata;
            end
            irq_q <= irq_vec & mask_q;
        end
    end

    assign fc_interrupts_o = irq_q;

    always_comb begin
        apb_resp_o.pready  = apb_req_i.psel & apb_req_i.penable;
        apb_resp_o.pslverr = 1'b0;
        apb_resp_o.prdata  = mask_hit ? mask_q : '0;
    end

    a_reserved_zero : assert property (@(posedge clk_i) disable iff (!rst_ni)
        (fc_interrupts_o & IrqReservedMask) == '0)
        else $error("reserved interrupt bit set");

endmodule

// File: rtl/soc_periph_top.sv
// Top level of the peripheral subsystem, connecting the APB decoder, register slaves and irq mapper
`timescale 1ns/1ns

module soc_periph_top
    import soc_bus_pkg::*;
    import soc_map_pkg::*;
(
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      slow_clk_i,
    input  apb_req_t                  apb_req_i,
    output apb_resp_t                 apb_resp_o,
    input  logic                      fc_fetch_en_valid_i,
    input  logic                      fc_fetch_en_i,
    output addr_t                     fc_bootaddr_o,
    output logic                      fc_fetchen_o,
    output cluster_ctrl_t             cluster_ctrl_o,
    input  logic                      dma_pe_evt_i,
    input  logic                      dma_pe_irq_i,
    input  logic                      pf_evt_i,
    input  logic                      gpio_evt_i,
    input  logic [NumAdvTimerEvt-1:0] adv_timer_evt_i,
    input  logic [NumHwpeEvt-1:0]     fc_hwpe_evt_i,
    output logic [NumIrq-1:0]         fc_interrupts_o
);

    apb_req_t            ctrl_req;
    apb_req_t            evt_req;
    apb_req_t            irq_req;
    apb_resp_t           ctrl_resp;
    apb_resp_t           evt_resp;
    apb_resp_t           irq_resp;
    logic [NumSwEvt-1:0] sw_evt;
    logic                ref_edge;

    ////////////////////
    // Bus side
    ////////////////////

    apb_addr_decode i_decode (
        .apb_req_i   ( apb_req_i  ),
        .apb_resp_o  ( apb_resp_o ),
        .ctrl_req_o  ( ctrl_req   ),
        .evt_req_o   ( evt_req    ),
        .irq_req_o   ( irq_req    ),
        .ctrl_resp_i ( ctrl_resp  ),
        .evt_resp_i  ( evt_resp   ),
        .irq_resp_i  ( irq_resp   )
    );

    soc_ctrl_regs i_ctrl (
        .clk_i               ( clk_i               ),
        .rst_ni              ( rst_ni              ),
        .apb_req_i           ( ctrl_req            ),
        .apb_resp_o          ( ctrl_resp           ),
        .fc_fetch_en_valid_i ( fc_fetch_en_valid_i ),
        .fc_fetch_en_i       ( fc_fetch_en_i       ),
        .fc_bootaddr_o       ( fc_bootaddr_o       ),
        .fc_fetchen_o        ( fc_fetchen_o        ),
        .cluster_ctrl_o      ( cluster_ctrl_o      )
    );

    ////////////////////
    // Event side
    ////////////////////

    soc_event_unit i_evt (
        .clk_i      ( clk_i      ),
        .rst_ni     ( rst_ni     ),
        .slow_clk_i ( slow_clk_i ),
        .apb_req_i  ( evt_req    ),
        .apb_resp_o ( evt_resp   ),
        .sw_evt_o   ( sw_evt     ),
        .ref_edge_o ( ref_edge   )
    );

    fc_irq_mapper i_irq (
        .clk_i           ( clk_i           ),
        .rst_ni          ( rst_ni          ),
        .apb_req_i       ( irq_req         ),
        .apb_resp_o      ( irq_resp        ),
        .sw_evt_i        ( sw_evt          ),
        .ref_edge_i      ( ref_edge        ),
        .dma_pe_evt_i    ( dma_pe_evt_i    ),
        .dma_pe_irq_i    ( dma_pe_irq_i    ),
        .pf_evt_i        ( pf_evt_i        ),
        .gpio_evt_i      ( gpio_evt_i      ),
        .adv_timer_evt_i ( adv_timer_evt_i ),
        .fc_hwpe_evt_i   ( fc_hwpe_evt_i   ),
        .fc_interrupts_o ( fc_interrupts_o )
    );

endmodule

// File: sim/tb_soc_periph.sv
// Table-driven testbench for the peripheral subsystem that runs with tb_soc_periph as top module
`timescale 1ns/1ns

module tb_soc_periph
    import soc_bus_pkg::*;
    import soc_map_pkg::*;
();

    localparam int unsigned ClkPeriod   = 100;
    localparam int unsigned ResetCycles = 16;
    localparam int unsigned EntryCycles = 20;

    localparam addr_t             BootReg    = CtrlStart + addr_t'(OFF_BOOTADDR);
    localparam addr_t             FetchReg   = CtrlStart + addr_t'(OFF_FETCHEN);
    localparam addr_t             ClusterReg = CtrlStart + addr_t'(OFF_CLUSTER);
    localparam logic [NumIrq-1:0] RefClkBit  = 32'(1) << IrqRefClk;

    typedef enum {K_WR, K_RD, K_RDERR, K_EVT, K_SLOW} kind_e;

    // Fetch strobe and direct event lines in 12 bits
    typedef struct packed {
        logic       fetch_valid;
        logic       fetch_en;
        logic       dma_pe_evt;
        logic       dma_pe_irq;
        logic       pf_evt;
        logic       gpio_evt;
        logic [3:0] adv_timer;
        logic [1:0] hwpe;
    } ev_t;

    typedef struct {
        kind_e kind;
        addr_t addr;
        data_t data;
        ev_t   ev;
        data_t exp;
    } entry_t;

    logic              clk_i = 1'b0;
    logic              rst_ni;
    logic              slow_clk_i;
    apb_req_t          apb_req;
    apb_resp_t         apb_resp;
    ev_t               ev_q;
    addr_t             bootaddr;
    logic              fetchen;
    cluster_ctrl_t     cluster;
    logic [NumIrq-1:0] fc_irq;
    entry_t            tbl[$];
    logic [31:0]       rng;
    bit                built;

    always #(ClkPeriod / 2) clk_i = ~clk_i;

    soc_periph_top uut (
        .clk_i               ( clk_i          ),
        .rst_ni              ( rst_ni         ),
        .slow_clk_i          ( slow_clk_i     ),
        .apb_req_i           ( apb_req        ),
        .apb_resp_o          ( apb_resp       ),
        .fc_fetch_en_valid_i ( ev_q.fetch_valid ),
        .fc_fetch_en_i       ( ev_q.fetch_en  ),
        .fc_bootaddr_o       ( bootaddr       ),
        .fc_fetchen_o        ( fetchen        ),
        .cluster_ctrl_o      ( cluster        ),
        .dma_pe_evt_i        ( ev_q.dma_pe_evt ),
        .dma_pe_irq_i        ( ev_q.dma_pe_irq ),
        .pf_evt_i            ( ev_q.pf_evt    ),
        .gpio_evt_i          ( ev_q.gpio_evt  ),
        .adv_timer_evt_i     ( ev_q.adv_timer ),
        .fc_hwpe_evt_i       ( ev_q.hwpe      ),
        .fc_interrupts_o     ( fc_irq         )
    );

    ////////////////////
    // Helpers
    ////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Expected vector from the fixed interrupt positions
    function automatic logic [NumIrq-1:0] map_events(input ev_t ev);
        logic [NumIrq-1:0] v;
        v                  = '0;
        v[IrqDmaPeEvt]     = ev.dma_pe_evt;
        v[IrqDmaPeIrq]     = ev.dma_pe_irq;
        v[IrqPfEvt]        = ev.pf_evt;
        v[IrqGpio]         = ev.gpio_evt;
        v[IrqAdvTimer +: 4] = ev.adv_timer;
        v[IrqHwpe +: 2]    = ev.hwpe;
        return v;
    endfunction

    task automatic abort_run();
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic data_check(input string name, input data_t act, input data_t exp);
        if (act !== exp) begin
            $display("[FAIL] t=%0t %s: got 0x%08h, expected 0x%08h", $time, name, act, exp);
            abort_run();
        end
    endtask

    task automatic irq_check(input string name, input logic [NumIrq-1:0] act,
                             input logic [NumIrq-1:0] exp);
        if (act !== exp) begin
            $display("[FAIL] t=%0t %s: got 0x%08h, expected 0x%08h", $time, name, act, exp);
            abort_run();
        end
    endtask

    task automatic cluster_check(input string name, input cluster_ctrl_t act,
                                 input cluster_ctrl_t exp);
        if (act !== exp) begin
            $display("[FAIL] t=%0t %s: got %b, expected %b", $time, name, act, exp);
            abort_run();
        end
    endtask

    task automatic error_check(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            $display("[FAIL] t=%0t %s: got %b, expected %b", $time, name, act, exp);
            abort_run();
        end
    endtask

    // One APB transfer with the fetch strobe on its access cycle
    task automatic apb_xfer(input logic wr, input addr_t a, input data_t d, input ev_t e,
                            output data_t rd, output logic err);
        @(posedge clk_i);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: a, pwdata: d};
        @(posedge clk_i);
        apb_req.penable  <= 1'b1;
        ev_q.fetch_valid <= e.fetch_valid;
        ev_q.fetch_en    <= e.fetch_en;
        @(negedge clk_i);
        while (!apb_resp.pready) @(negedge clk_i);
        rd  = apb_resp.prdata;
        err = apb_resp.pslverr;
        @(posedge clk_i);
        apb_req          <= '0;
        ev_q.fetch_valid <= 1'b0;
    endtask

    task automatic add_entry(input kind_e k, input addr_t a, input data_t d, input ev_t e,
                             input data_t x);
        tbl.push_back('{kind: k, addr: a, data: d, ev: e, exp: x});
    endtask

    ////////////////////
    // Stimulus table
    ////////////////////

    task automatic build_table();
        data_t mask_m;
        ev_t   e;
        mask_m = IrqMaskRst;
        add_entry(K_RD, BootReg, '0, '0, BootAddrRst);
        add_entry(K_RD, FetchReg, '0, '0, '0);
        add_entry(K_RD, ClusterReg, '0, '0, '0);
        add_entry(K_RD, IrqStart, '0, '0, IrqMaskRst);
        add_entry(K_RD, EvtStart, '0, '0, '0);
        for (int i = 0; i < 3; i++) begin
            rng = xorshift32(rng);
            add_entry(K_WR, BootReg, rng, '0, rng);
            add_entry(K_RD, BootReg, '0, '0, rng);
            rng = xorshift32(rng);
            add_entry(K_WR, FetchReg, rng, '0, data_t'(rng[0]));
            add_entry(K_RD, FetchReg, '0, '0, data_t'(rng[0]));
            rng = xorshift32(rng);
            add_entry(K_WR, ClusterReg, rng, '0, data_t'(rng[3:0]));
            add_entry(K_RD, ClusterReg, '0, '0, data_t'(rng[3:0]));
        end
        add_entry(K_RDERR, 32'h1A10_5000, '0, '0, '0);
        add_entry(K_RDERR, 32'h0000_0100, '0, '0, '0);
        // Strobe against a bus write of the opposite value
        add_entry(K_WR, FetchReg, 32'h0, ev_t'(12'hC00), 32'h1);
        add_entry(K_RD, FetchReg, '0, '0, 32'h1);
        add_entry(K_WR, FetchReg, 32'h1, ev_t'(12'h800), 32'h0);
        add_entry(K_RD, FetchReg, '0, '0, 32'h0);
        rng    = xorshift32(rng);
        mask_m = rng;
        add_entry(K_WR, IrqStart, rng, '0, rng);
        add_entry(K_RD, IrqStart, '0, '0, rng);
        for (int i = 0; i < 4; i++) begin
            rng = xorshift32(rng);
            e   = ev_t'({2'b00, rng[9:0]});
            add_entry(K_EVT, '0, '0, e, map_events(e) & mask_m);
        end
        rng = xorshift32(rng);
        add_entry(K_WR, EvtStart, rng, '0, data_t'(rng[7:0]) & mask_m);
        add_entry(K_RD, EvtStart, '0, '0, data_t'(rng[7:0]));
        mask_m = mask_m | RefClkBit;
        add_entry(K_WR, IrqStart, mask_m, '0, mask_m);
        add_entry(K_SLOW, '0, '0, '0, 32'd1);
        add_entry(K_SLOW, '0, '0, '0, 32'd1);
        mask_m = mask_m & ~RefClkBit;
        add_entry(K_WR, IrqStart, mask_m, '0, mask_m);
        add_entry(K_SLOW, '0, '0, '0, 32'd0);
    endtask

    // Watchdog
    initial begin
        wait (built);
        #((tbl.size() * EntryCycles + ResetCycles) * ClkPeriod);
        $display("Timeout: the stimulus table did not finish in time");
        abort_run();
    end

    initial begin
        entry_t e;
        data_t  rd;
        logic   err;
        int     hits;
        int     first;
        rst_ni     = 1'b0;
        slow_clk_i = 1'b0;
        apb_req    = '0;
        ev_q       = '0;
        rng        = 32'd7;
        build_table();
        built = 1'b1;
        repeat (ResetCycles) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(negedge clk_i);
        irq_check("fc_interrupts_o", fc_irq, '0);
        foreach (tbl[i]) begin
            e = tbl[i];
            case (e.kind)
                K_WR: begin
                    apb_xfer(1'b1, e.addr, e.data, e.ev, rd, err);
                    error_check("pslverr", err, 1'b0);
                    @(negedge clk_i);
                    case (e.addr)
                        BootReg:    data_check("fc_bootaddr_o", bootaddr, e.exp);
                        FetchReg:   data_check("fc_fetchen_o", data_t'(fetchen), e.exp);
                        ClusterReg: cluster_check("cluster_ctrl_o", cluster,
                                                  cluster_ctrl_t'(e.exp[3:0]));
                        EvtStart: begin
                            // Byte shows on the vector for one cycle two cycles after completion
                            irq_check("fc_interrupts_o", fc_irq, '0);
                            @(negedge clk_i);
                            irq_check("fc_interrupts_o", fc_irq, e.exp);
                            @(negedge clk_i);
                            irq_check("fc_interrupts_o", fc_irq, '0);
                        end
                        default: ;
                    endcase
                end
                K_RD: begin
                    apb_xfer(1'b0, e.addr, '0, '0, rd, err);
                    error_check("pslverr", err, 1'b0);
                    data_check("prdata", rd, e.exp);
                end
                K_RDERR: begin
                    apb_xfer(1'b0, e.addr, '0, '0, rd, err);
                    error_check("pslverr", err, 1'b1);
                    data_check("prdata", rd, '0);
                end
                K_EVT: begin
                    @(posedge clk_i);
                    ev_q <= e.ev;
                    @(negedge clk_i);
                    irq_check("fc_interrupts_o", fc_irq, '0);
                    @(posedge clk_i);
                    ev_q <= '0;
                    @(negedge clk_i);
                    irq_check("fc_interrupts_o", fc_irq, e.exp);
                    @(negedge clk_i);
                    irq_check("fc_interrupts_o", fc_irq, '0);
                end
                K_SLOW: begin
                    @(posedge clk_i);
                    slow_clk_i <= ~slow_clk_i;
                    hits  = 0;
                    first = -1;
                    for (int k = 0; k < 8; k++) begin
                        @(negedge clk_i);
                        irq_check("fc_interrupts_o", fc_irq & ~RefClkBit, '0);
                        if (fc_irq[IrqRefClk]) begin
                            hits++;
                            if (first < 0) first = k;
                        end
                    end
                    // A pulse must land three to five cycles after the toggle
                    if (hits != int'(e.exp) || (hits > 0 && (first < 3 || first > 5))) begin
                        $display("Slow clock toggle gave %0d pulses on bit 14 from cycle %0d",
                                 hits, first);
                        $display("Expected %0d pulse within cycles 3 to 5", e.exp);
                        abort_run();
                    end
                end
                default: ;
            endcase
        end
        $display("Verification passed");
        $finish;
    end

endmodule

// File: all.f
rtl/soc_bus_pkg.sv
rtl/soc_map_pkg.sv
rtl/apb_addr_decode.sv
rtl/soc_ctrl_regs.sv
rtl/soc_event_unit.sv
rtl/fc_irq_mapper.sv
rtl/soc_periph_top.sv
sim/tb_soc_periph.sv

// File: Bender.yml
package:
  name: soc_periph

sources:
  # Packages first, then the slaves and the top level
  - rtl/soc_bus_pkg.sv
  - rtl/soc_map_pkg.sv
  - rtl/apb_addr_decode.sv
  - rtl/soc_ctrl_regs.sv
  - rtl/soc_event_unit.sv
  - rtl/fc_irq_mapper.sv
  - rtl/soc_periph_top.sv
  - target: simulation
    files:
      - sim/tb_soc_periph.sv
